/* sim.f */
common/endec_pkg.sv
rtl/endec_control.sv
rtl/frame_slicer.sv
rtl/conv_encoder.sv
viterbi/add_compare_select.sv
viterbi/survivor_memory.sv
viterbi/traceback.sv
rtl/endec.sv
test/endec_asserts.sv
test/endec_checker.sv
test/endec_tb.sv

/* Makefile */
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module endec_tb -Mdir obj_dir -f sim.f

run: build
	./obj_dir/Vendec_tb 2>&1 | tee sim.log
	@if grep -q "Simulation FAILED" sim.log; then exit 1; fi
	@if ! grep -q "Simulation PASSED" sim.log; then exit 1; fi

lint:
	verilator --lint-only --timing --top-module endec_tb -f sim.f

clean:
	rm -rf obj_dir sim.log

/* test/endec_tb.sv */
`timescale 1ns/1ps

module endec_tb;
    import endec_pkg::*;

    localparam int FRAME_BITS = 16;
    localparam int LIMIT      = 30 * (2*FRAME_BITS + 6);
    localparam int NUM_RUNS   = 16;

    logic                    sys_clk;
    logic                    i_reset;
    logic                    i_en;
    gen_poly_t               i_gen_poly;
    logic [STATE_BITS-1:0]   i_prv_encoder_state;
    logic [FRAME_BITS-1:0]   i_encoder_data_frame;
    logic [2*FRAME_BITS-1:0] i_decoder_data_frame;
    logic [2*FRAME_BITS-1:0] o_encoder_data;
    logic                    o_encoder_done;
    logic [FRAME_BITS-1:0]   o_decoder_data;
    logic                    o_decoder_done;

    logic [2*FRAME_BITS-1:0] exp_enc;
    logic [FRAME_BITS-1:0]   exp_dec;
    logic                    check_dec;
    int                      data_errors;
    int                      timing_errors;
    int                      runs;
    int                      cycle_count = 0;

    endec #(.FRAME_BITS(FRAME_BITS)) dut (.*);

    endec_checker #(.FRAME_BITS(FRAME_BITS)) monitor (
        .sys_clk         (sys_clk),
        .i_reset         (i_reset),
        .i_en            (i_en),
        .i_encoder_data  (o_encoder_data),
        .i_encoder_done  (o_encoder_done),
        .i_decoder_data  (o_decoder_data),
        .i_decoder_done  (o_decoder_done),
        .i_exp_enc       (exp_enc),
        .i_exp_dec       (exp_dec),
        .i_check_dec     (check_dec),
        .o_data_errors   (data_errors),
        .o_timing_errors (timing_errors),
        .o_runs          (runs)
    );

    // rate 1/2 encoder, data LSB first, newest bit in state bit 1
    function automatic logic [2*FRAME_BITS-1:0] encode_ref(gen_poly_t poly,
                                                           logic [1:0] st,
                                                           logic [FRAME_BITS-1:0] data);
        logic [2*FRAME_BITS-1:0] code;
        logic [2:0]              taps;
        code = '0;
        for (int n = 0; n < FRAME_BITS; n++)
        begin
            taps        = {data[n], st};
            code[2*n]   = ^(taps & poly.g0);
            code[2*n+1] = ^(taps & poly.g1);
            st          = {data[n], st[1]};
        end
        return code;
    endfunction

    initial
    begin
        sys_clk = 1'b0;
        forever #10 sys_clk = ~sys_clk;
    end

    always @(posedge sys_clk)
    begin
        cycle_count++;
        if (cycle_count >= LIMIT)
        begin
            $display("timeout: the run did not finish within %0d cycles", LIMIT);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic run_frame(input gen_poly_t poly, input logic [1:0] st,
                             input logic [FRAME_BITS-1:0] data,
                             input logic [2*FRAME_BITS-1:0] rx_frame,
                             input logic [FRAME_BITS-1:0] rx_data,
                             input logic chk, input logic busy_pulse);
        @(posedge sys_clk);
        #2;
        i_gen_poly           = poly;
        i_prv_encoder_state  = st;
        i_encoder_data_frame = data;
        i_decoder_data_frame = rx_frame;
        exp_enc              = encode_ref(poly, st, data);
        exp_dec              = rx_data;
        check_dec            = chk;
        i_en                 = 1'b1;
        @(posedge sys_clk);
        #2;
        i_en = 1'b0;
        if (busy_pulse)
        begin
            repeat (5) @(posedge sys_clk);
            #2;
            i_en = 1'b1;
            @(posedge sys_clk);
            #2;
            i_en = 1'b0;
        end
        do
            @(posedge sys_clk);
        while (!o_decoder_done);
    endtask

    initial
    begin
        gen_poly_t               poly;
        logic [FRAME_BITS-1:0]   data;
        logic [FRAME_BITS-1:0]   rx_data;
        logic [2*FRAME_BITS-1:0] rx_frame;
        int                      a;
        int                      b;
        void'($urandom(37));
        i_reset              = 1'b1;
        i_en                 = 1'b0;
        i_gen_poly           = '0;
        i_prv_encoder_state  = '0;
        i_encoder_data_frame = '0;
        i_decoder_data_frame = '0;
        exp_enc              = '0;
        exp_dec              = '0;
        check_dec            = 1'b0;
        repeat (3) @(posedge sys_clk);
        #2;
        i_reset = 1'b0;

        // -------------------
        // polynomials 7/5, encoding with clean and corrupted decoding
        // -------------------
        poly.g0 = 3'd7;
        poly.g1 = 3'd5;
        for (int i = 0; i < 10; i++)
        begin
            data     = FRAME_BITS'($urandom());
            rx_data  = FRAME_BITS'($urandom());
            rx_frame = encode_ref(poly, 2'b00, rx_data);
            // errors stay clear of the unterminated frame tail
            if (i % 3 == 1)
            begin
                a = $urandom_range(0, 2*FRAME_BITS - 9);
                rx_frame[a] = ~rx_frame[a];
            end
            else if (i % 3 == 2)
            begin
                a = $urandom_range(0, 11);
                b = $urandom_range(a + 12, 2*FRAME_BITS - 9);
                rx_frame[a] = ~rx_frame[a];
                rx_frame[b] = ~rx_frame[b];
            end
            run_frame(poly, 2'($urandom()), data, rx_frame, rx_data, 1'b1, i == 4);
        end

        // -------------------
        // other polynomial pairs, encoder only
        // -------------------
        for (int i = 0; i < 6; i++)
        begin
            poly.g0  = (i < 3) ? 3'd3 : 3'd7;
            poly.g1  = (i < 3) ? 3'd6 : 3'd7;
            data     = FRAME_BITS'($urandom());
            rx_frame = (2*FRAME_BITS)'({$urandom(), $urandom()});
            run_frame(poly, 2'($urandom()), data, rx_frame, '0, 1'b0, 1'b0);
        end

        // reset again with nonzero outputs
        @(posedge sys_clk);
        #2;
        i_reset = 1'b1;
        repeat (3) @(posedge sys_clk);
        #2;
        i_reset = 1'b0;
        repeat (3) @(posedge sys_clk);

        $display("errors: data %0d, timing %0d, runs %0d of %0d",
                 data_errors, timing_errors, runs, NUM_RUNS);
        if (data_errors == 0 && timing_errors == 0 && runs == NUM_RUNS)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

/* test/endec_checker.sv */
`timescale 1ns/1ps

module endec_checker #(
    parameter int FRAME_BITS = 16
) (
    input  logic                    sys_clk,
    input  logic                    i_reset,
    input  logic                    i_en,
    input  logic [2*FRAME_BITS-1:0] i_encoder_data,
    input  logic                    i_encoder_done,
    input  logic [FRAME_BITS-1:0]   i_decoder_data,
    input  logic                    i_decoder_done,
    input  logic [2*FRAME_BITS-1:0] i_exp_enc,
    input  logic [FRAME_BITS-1:0]   i_exp_dec,
    input  logic                    i_check_dec,
    output int                      o_data_errors,
    output int                      o_timing_errors,
    output int                      o_runs
);

    logic                    busy = 1'b0;
    logic                    after_reset = 1'b0;
    int                      cyc = 0;
    int                      enc_seen = 0;
    logic [2*FRAME_BITS-1:0] exp_enc_q;
    logic [FRAME_BITS-1:0]   exp_dec_q;
    logic                    check_dec_q;

    initial
    begin
        o_data_errors   = 0;
        o_timing_errors = 0;
        o_runs          = 0;
    end

    // samples at the rising edge, so every value is the one of the cycle before
    always @(posedge sys_clk)
    begin
        if (i_reset)
        begin
            busy        = 1'b0;
            after_reset = 1'b1;
        end
        else
        begin
            if (after_reset && (i_encoder_data !== '0 || i_decoder_data !== '0))
            begin
                $display("[ERROR] %0t: data outputs not zero after reset", $time);
                o_data_errors++;
            end
            after_reset = 1'b0;
            if (busy)
            begin
                cyc++;
                if (i_encoder_done)
                begin
                    enc_seen++;
                    if (cyc != FRAME_BITS + 1)
                    begin
                        $display("[ERROR] %0t: encoder done at cycle %0d", $time, cyc);
                        o_timing_errors++;
                    end
                    if (i_encoder_data !== exp_enc_q)
                    begin
                        $display("[ERROR] %0t: encoder data %h, expected %h",
                                 $time, i_encoder_data, exp_enc_q);
                        o_data_errors++;
                    end
                end
                if (i_decoder_done)
                begin
                    if (cyc != 2*FRAME_BITS + 2 || enc_seen != 1)
                    begin
                        $display("[ERROR] %0t: decoder done at cycle %0d, %0d encoder dones",
                                 $time, cyc, enc_seen);
                        o_timing_errors++;
                    end
                    if (check_dec_q && i_decoder_data !== exp_dec_q)
                    begin
                        $display("[ERROR] %0t: decoder data %h, expected %h",
                                 $time, i_decoder_data, exp_dec_q);
                        o_data_errors++;
                    end
                    busy = 1'b0;
                    o_runs++;
                end
                else if (cyc > 2*FRAME_BITS + 2)
                begin
                    $display("[ERROR] %0t: decoder done is missing", $time);
                    o_timing_errors++;
                    busy = 1'b0;
                end
            end
            else
            begin
                if (i_encoder_done || i_decoder_done)
                begin
                    $display("[ERROR] %0t: done pulse while idle", $time);
                    o_timing_errors++;
                end
                if (i_en)
                begin
                    busy        = 1'b1;
                    cyc         = 0;
                    enc_seen    = 0;
                    exp_enc_q   = i_exp_enc;
                    exp_dec_q   = i_exp_dec;
                    check_dec_q = i_check_dec;
                end
            end
        end
    end

endmodule

/* test/endec_asserts.sv */
`timescale 1ns/1ps

module endec_asserts #(
    parameter int FRAME_BITS = 16
) (
    input logic sys_clk,
    input logic i_reset,
    input logic o_encoder_done,
    input logic o_decoder_done
);

    // done outputs are single-cycle pulses
    enc_pulse: assert property (@(posedge sys_clk) disable iff (i_reset)
        o_encoder_done |=> !o_encoder_done)
        else $error("o_encoder_done stayed high for more than one cycle");

    dec_pulse: assert property (@(posedge sys_clk) disable iff (i_reset)
        o_decoder_done |=> !o_decoder_done)
        else $error("o_decoder_done stayed high for more than one cycle");

    // traceback always takes FRAME_BITS steps plus the done cycle
    dec_follows_enc: assert property (@(posedge sys_clk) disable iff (i_reset)
        o_encoder_done |-> ##(FRAME_BITS+1) o_decoder_done)
        else $error("o_decoder_done did not follow o_encoder_done in time");

    done_low_in_reset: assert property (@(posedge sys_clk)
        i_reset |=> (!o_encoder_done && !o_decoder_done))
        else $error("a done output was high during reset");

endmodule

bind endec endec_asserts #(.FRAME_BITS(FRAME_BITS)) asserts (
    .sys_clk        (sys_clk),
    .i_reset        (i_reset),
    .o_encoder_done (o_encoder_done),
    .o_decoder_done (o_decoder_done)
);

/* rtl/endec.sv */
`timescale 1ns/1ps

module endec #(
    parameter int FRAME_BITS = 16
) (
    input  logic                             sys_clk,
    input  logic                             i_reset,
    input  logic                             i_en,
    input  endec_pkg::gen_poly_t             i_gen_poly,
    input  logic [endec_pkg::STATE_BITS-1:0] i_prv_encoder_state,
    input  logic [FRAME_BITS-1:0]            i_encoder_data_frame,
    input  logic [2*FRAME_BITS-1:0]          i_decoder_data_frame,
    output logic [2*FRAME_BITS-1:0]          o_encoder_data,
    output logic                             o_encoder_done,
    output logic [FRAME_BITS-1:0]            o_decoder_data,
    output logic                             o_decoder_done
);
    import endec_pkg::*;

    localparam int STEP_W = $clog2(FRAME_BITS);

    step_ctrl_t                     ctrl;
    logic                           tx_bit;
    symbol_t                        rx_sym;
    symbol_t [NUM_STATES-1:0][1:0]  branch_sym;
    logic [NUM_STATES-1:0]          dec_vec;
    logic [STATE_BITS-1:0]          best_state;
    logic [STEP_W-1:0]              rd_step;
    logic [NUM_STATES-1:0]          rd_vec;

    endec_control #(.FRAME_BITS(FRAME_BITS)) control (
        .sys_clk        (sys_clk),
        .i_reset        (i_reset),
        .i_en           (i_en),
        .o_ctrl         (ctrl),
        .o_encoder_done (o_encoder_done),
        .o_decoder_done (o_decoder_done)
    );

    // --------------------
    // forward pass
    // --------------------
    frame_slicer #(.FRAME_BITS(FRAME_BITS)) slicer (
        .sys_clk              (sys_clk),
        .i_reset              (i_reset),
        .i_ctrl               (ctrl),
        .i_encoder_data_frame (i_encoder_data_frame),
        .i_decoder_data_frame (i_decoder_data_frame),
        .o_tx_bit             (tx_bit),
        .o_rx_sym             (rx_sym)
    );

    conv_encoder #(.FRAME_BITS(FRAME_BITS)) encoder (
        .sys_clk             (sys_clk),
        .i_reset             (i_reset),
        .i_ctrl              (ctrl),
        .i_gen_poly          (i_gen_poly),
        .i_prv_encoder_state (i_prv_encoder_state),
        .i_tx_bit            (tx_bit),
        .o_branch_sym        (branch_sym),
        .o_encoder_data      (o_encoder_data)
    );

    add_compare_select acs (
        .sys_clk      (sys_clk),
        .i_reset      (i_reset),
        .i_ctrl       (ctrl),
        .i_rx_sym     (rx_sym),
        .i_branch_sym (branch_sym),
        .o_dec_vec    (dec_vec),
        .o_best_state (best_state)
    );

    // --------------------
    // survivors and traceback
    // --------------------
    survivor_memory #(.FRAME_BITS(FRAME_BITS)) memory (
        .sys_clk   (sys_clk),
        .i_reset   (i_reset),
        .i_ctrl    (ctrl),
        .i_dec_vec (dec_vec),
        .i_rd_step (rd_step),
        .o_rd_vec  (rd_vec)
    );

    traceback #(.FRAME_BITS(FRAME_BITS)) trace (
        .sys_clk        (sys_clk),
        .i_reset        (i_reset),
        .i_ctrl         (ctrl),
        .i_best_state   (best_state),
        .i_rd_vec       (rd_vec),
        .o_rd_step      (rd_step),
        .o_decoder_data (o_decoder_data)
    );

endmodule

/* viterbi/traceback.sv */
`timescale 1ns/1ps

module traceback #(
    parameter  int FRAME_BITS = 16,
    localparam int STEP_W     = $clog2(FRAME_BITS)
) (
    input  logic                             sys_clk,
    input  logic                             i_reset,
    input  endec_pkg::step_ctrl_t            i_ctrl,
    input  logic [endec_pkg::STATE_BITS-1:0] i_best_state,
    input  logic [endec_pkg::NUM_STATES-1:0] i_rd_vec,
    output logic [STEP_W-1:0]                o_rd_step,
    output logic [FRAME_BITS-1:0]            o_decoder_data
);
    import endec_pkg::*;

    localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(FRAME_BITS - 1);

    logic [STATE_BITS-1:0] state_q;
    logic [STATE_BITS-1:0] cur_state;
    logic [STEP_W-1:0]     step_q;

    // first step starts straight from the acs winner at the last step
    assign cur_state = i_ctrl.trace_first ? i_best_state : state_q;
    assign o_rd_step = i_ctrl.trace_first ? LAST_STEP : step_q;

    always_ff @(posedge sys_clk)
    begin
        if (i_reset)
        begin
            state_q        <= '0;
            step_q         <= '0;
            o_decoder_data <= '0;
        end
        else if (i_ctrl.trace_en)
        begin
            // predecessor = low state bits followed by the stored decision
            state_q        <= {cur_state[STATE_BITS-2:0], i_rd_vec[cur_state]};
            step_q         <= o_rd_step - 1'b1;
            // last step enters first and ends up in the msb
            o_decoder_data <= {o_decoder_data[FRAME_BITS-2:0], cur_state[STATE_BITS-1]};
        end
    end

endmodule

/* viterbi/survivor_memory.sv */
`timescale 1ns/1ps

module survivor_memory #(
    parameter  int FRAME_BITS = 16,
    localparam int STEP_W     = $clog2(FRAME_BITS)
) (
    input  logic                            sys_clk,
    input  logic                            i_reset,
    input  endec_pkg::step_ctrl_t           i_ctrl,
    input  logic [endec_pkg::NUM_STATES-1:0] i_dec_vec,
    input  logic [STEP_W-1:0]               i_rd_step,
    output logic [endec_pkg::NUM_STATES-1:0] o_rd_vec
);
    import endec_pkg::*;

    logic [NUM_STATES-1:0] mem [FRAME_BITS];
    logic [STEP_W-1:0]     wr_ptr;

    // pointer rests at zero between forward passes
    always_ff @(posedge sys_clk)
    begin
        if (i_reset || !i_ctrl.mem_wr)
            wr_ptr <= '0;
        else
            wr_ptr <= wr_ptr + 1'b1;
    end

    always_ff @(posedge sys_clk)
    begin
        if (i_ctrl.mem_wr)
            mem[wr_ptr] <= i_dec_vec;
    end

    assign o_rd_vec = mem[i_rd_step];

endmodule

/* viterbi/add_compare_select.sv */
`timescale 1ns/1ps

module add_compare_select (
    input  logic                                          sys_clk,
    input  logic                                          i_reset,
    input  endec_pkg::step_ctrl_t                         i_ctrl,
    input  endec_pkg::symbol_t                            i_rx_sym,
    input  endec_pkg::symbol_t [endec_pkg::NUM_STATES-1:0][1:0] i_branch_sym,
    output logic [endec_pkg::NUM_STATES-1:0]              o_dec_vec,
    output logic [endec_pkg::STATE_BITS-1:0]              o_best_state
);
    import endec_pkg::*;

    localparam logic [METRIC_W-1:0] METRIC_MAX = '1;

    logic [METRIC_W-1:0] pm_q    [NUM_STATES];
    logic [METRIC_W-1:0] pm_next [NUM_STATES];

    function automatic logic [1:0] hamming(symbol_t a, symbol_t b);
        symbol_t diff;
        diff = a ^ b;
        return {1'b0, diff[0]} + {1'b0, diff[1]};
    endfunction

    // unreachable start states sit at the maximum, so the add saturates
    function automatic logic [METRIC_W-1:0] sat_add(logic [METRIC_W-1:0] pm, logic [1:0] bm);
        logic [METRIC_W:0] sum;
        sum = {1'b0, pm} + {{(METRIC_W-1){1'b0}}, bm};
        return sum[METRIC_W] ? METRIC_MAX : sum[METRIC_W-1:0];
    endfunction

    // --------------------
    // add, compare, select
    // --------------------
    always_comb
    begin
        logic [STATE_BITS-1:0] dst;
        logic [STATE_BITS-1:0] p0;
        logic [STATE_BITS-1:0] p1;
        logic [METRIC_W-1:0]   c0;
        logic [METRIC_W-1:0]   c1;
        for (int d = 0; d < NUM_STATES; d++)
        begin
            dst = STATE_BITS'(d);
            // both predecessors share the low state bits, input bit is dst msb
            p0  = {dst[STATE_BITS-2:0], 1'b0};
            p1  = {dst[STATE_BITS-2:0], 1'b1};
            c0  = sat_add(pm_q[p0], hamming(i_rx_sym, i_branch_sym[p0][dst[STATE_BITS-1]]));
            c1  = sat_add(pm_q[p1], hamming(i_rx_sym, i_branch_sym[p1][dst[STATE_BITS-1]]));
            o_dec_vec[d] = (c1 < c0);
            pm_next[d]   = (c1 < c0) ? c1 : c0;
        end
    end

    always_ff @(posedge sys_clk)
    begin
        if (i_reset || i_ctrl.trace_first)
        begin
            for (int s = 0; s < NUM_STATES; s++)
                pm_q[s] <= (s == 0) ? '0 : METRIC_MAX;
        end
        else if (i_ctrl.acs_en)
            pm_q <= pm_next;
    end

    // lowest final metric, lowest index wins a tie
    always_comb
    begin
        logic [STATE_BITS-1:0] best_idx;
        logic [METRIC_W-1:0]   best_pm;
        best_idx = '0;
        best_pm  = pm_q[0];
        for (int s = 1; s < NUM_STATES; s++)
        begin
            if (pm_q[s] < best_pm)
            begin
                best_idx = STATE_BITS'(s);
                best_pm  = pm_q[s];
            end
        end
        o_best_state = best_idx;
    end

endmodule

/* rtl/conv_encoder.sv */
`timescale 1ns/1ps

module conv_encoder #(
    parameter int FRAME_BITS = 16
) (
    input  logic                                          sys_clk,
    input  logic                                          i_reset,
    input  endec_pkg::step_ctrl_t                         i_ctrl,
    input  endec_pkg::gen_poly_t                          i_gen_poly,
    input  logic [endec_pkg::STATE_BITS-1:0]              i_prv_encoder_state,
    input  logic                                          i_tx_bit,
    output endec_pkg::symbol_t [endec_pkg::NUM_STATES-1:0][1:0] o_branch_sym,
    output logic [2*FRAME_BITS-1:0]                       o_encoder_data
);
    import endec_pkg::*;

    gen_poly_t             poly_q;
    logic [STATE_BITS-1:0] state_q;
    symbol_t               sym;

    function automatic symbol_t code_sym(gen_poly_t poly, logic in_bit,
                                         logic [STATE_BITS-1:0] st);
        logic [CONSTRAINT_LEN-1:0] taps;
        taps = {in_bit, st};
        return {^(taps & poly.g1), ^(taps & poly.g0)};
    endfunction

    assign sym = code_sym(poly_q, i_tx_bit, state_q);

    // expected symbol for every branch, indexed by source state and input bit
    always_comb
    begin
        for (int s = 0; s < NUM_STATES; s++)
        begin
            for (int b = 0; b < 2; b++)
            begin
                o_branch_sym[s][b] = code_sym(poly_q, 1'(b), STATE_BITS'(s));
            end
        end
    end

    always_ff @(posedge sys_clk)
    begin
        if (i_reset)
        begin
            poly_q         <= '0;
            state_q        <= '0;
            o_encoder_data <= '0;
        end
        else if (!i_ctrl.encode_en)
        begin
            poly_q  <= i_gen_poly;
            state_q <= i_prv_encoder_state;
        end
        else
        begin
            // newest bit enters at the top of the state
            state_q        <= {i_tx_bit, state_q[STATE_BITS-1:1]};
            o_encoder_data <= {sym, o_encoder_data[2*FRAME_BITS-1:2]};
        end
    end

endmodule

/* rtl/frame_slicer.sv */
`timescale 1ns/1ps

module frame_slicer #(
    parameter int FRAME_BITS = 16
) (
    input  logic                    sys_clk,
    input  logic                    i_reset,
    input  endec_pkg::step_ctrl_t   i_ctrl,
    input  logic [FRAME_BITS-1:0]   i_encoder_data_frame,
    input  logic [2*FRAME_BITS-1:0] i_decoder_data_frame,
    output logic                    o_tx_bit,
    output endec_pkg::symbol_t      o_rx_sym
);
    import endec_pkg::*;

    localparam int SYM_W = $bits(symbol_t);

    logic [FRAME_BITS-1:0]       tx_q;
    logic [SYM_W*FRAME_BITS-1:0] rx_q;

    // frames are captured while no step runs, so the start edge loads them
    always_ff @(posedge sys_clk)
    begin
        if (i_reset)
        begin
            tx_q <= '0;
            rx_q <= '0;
        end
        else if (!i_ctrl.slice_en)
        begin
            tx_q <= i_encoder_data_frame;
            rx_q <= i_decoder_data_frame;
        end
        else
        begin
            tx_q <= tx_q >> 1;
            rx_q <= rx_q >> SYM_W;
        end
    end

    assign o_tx_bit = tx_q[0];
    assign o_rx_sym = rx_q[SYM_W-1:0];

endmodule

/* rtl/endec_control.sv */
`timescale 1ns/1ps

module endec_control #(
    parameter int FRAME_BITS = 16
) (
    input  logic                  sys_clk,
    input  logic                  i_reset,
    input  logic                  i_en,
    output endec_pkg::step_ctrl_t o_ctrl,
    output logic                  o_encoder_done,
    output logic                  o_decoder_done
);

    localparam int CNT_W = $clog2(FRAME_BITS + 1);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(FRAME_BITS);

    typedef enum logic [1:0] {
        S_IDLE,
        S_FORWARD,
        S_TRACE
    } state_t;

    state_t           state;
    logic [CNT_W-1:0] cnt;
    logic             at_last;

    // the cycle after the last step of a pass carries the done pulse
    assign at_last = (cnt == LAST);

    always_ff @(posedge sys_clk)
    begin
        if (i_reset)
        begin
            state <= S_IDLE;
            cnt   <= '0;
        end
        else
        begin
            case (state)
                S_IDLE:
                begin
                    if (i_en)
                        state <= S_FORWARD;
                end
                S_FORWARD, S_TRACE:
                begin
                    if (at_last)
                    begin
                        state <= (state == S_FORWARD) ? S_TRACE : S_IDLE;
                        cnt   <= '0;
                    end
                    else
                        cnt <= cnt + 1'b1;
                end
                default:
                    state <= S_IDLE;
            endcase
        end
    end

    // --------------------
    // step enables
    // --------------------
    always_comb
    begin
        o_ctrl = '0;
        if (state == S_FORWARD && !at_last)
        begin
            o_ctrl.slice_en  = 1'b1;
            o_ctrl.encode_en = 1'b1;
            o_ctrl.acs_en    = 1'b1;
            o_ctrl.mem_wr    = 1'b1;
        end
        if (state == S_TRACE && !at_last)
        begin
            o_ctrl.trace_en    = 1'b1;
            o_ctrl.trace_first = (cnt == '0);
        end
    end

    assign o_encoder_done = (state == S_FORWARD) && at_last;
    assign o_decoder_done = (state == S_TRACE) && at_last;

endmodule

/* common/endec_pkg.sv */
package endec_pkg;

    // --------------------
    // trellis constants
    // --------------------
    localparam int CONSTRAINT_LEN = 3;
    localparam int STATE_BITS     = CONSTRAINT_LEN - 1;
    localparam int NUM_STATES     = 1 << STATE_BITS;

    // 16 steps of at most 2 each stay well clear of the saturated start value
    localparam int METRIC_W       = 7;

    // --------------------
    // shared types
    // --------------------

    // bit 2 taps the new input bit, bits 1 and 0 tap the state
    typedef struct packed {
        logic [CONSTRAINT_LEN-1:0] g1;
        logic [CONSTRAINT_LEN-1:0] g0;
    } gen_poly_t;

    // g0 code bit in bit 0
    typedef logic [1:0] symbol_t;

    typedef struct packed {
        logic slice_en;
        logic encode_en;
        logic acs_en;
        logic mem_wr;
        logic trace_en;
        logic trace_first;
    } step_ctrl_t;

endpackage
